// ==== run_sim.sh ====
#!/bin/sh
# build and run the marker lock testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module am_lock_tb -f sources.f \
	--Mdir obj_dir -o am_lock_sim

./obj_dir/am_lock_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
if ! grep -q "All checks passed" sim.log; then
	echo "simulation ended without a pass report"
	exit 1
fi
echo "simulation passed"

// ==== sources.f ====
src/pcs_block_pkg.sv
src/am_lock_pkg.sv
src/am_match_if.sv
src/am_lock_comparator.sv
src/am_period_timer.sv
src/am_lock_fsm.sv
src/bip_error_counter.sv
src/am_lock_module.sv
verification/clock_gen.sv
verification/am_lock_assertions.sv
verification/am_lock_tb.sv

// ==== src/am_lock_comparator.sv ====
// alignment marker comparator
`timescale 1ns/1ps

module am_lock_comparator
#(
	parameter int N_ALIGNER = 20
)
(
	am_match_if.comparator              ifc,
	input  pcs_block_pkg::coded_block_t i_candidate
);

	import pcs_block_pkg::*;

	sync_hdr_t  sync_hdr;
	am_marker_t marker;
	logic       sh_valid;

	assign sync_hdr = i_candidate[LEN_CODED_BLOCK-1 -: 2];
	assign sh_valid = (sync_hdr == CTRL_SH);  // markers are control blocks only

	// BIP3 in 39:32 and BIP7 in 7:0 are not part of the pattern
	assign marker = {i_candidate[63:40], i_candidate[31:8]};

	// per lane compare
	always_comb
	begin
		for (int i = 0; i < N_ALIGNER; i++)
		begin
			ifc.match_vector[i] = sh_valid
				&& (marker == AM_TABLE[i])
				&& (!ifc.enable_mask || ifc.match_mask[i]);  // after capture only own lane
		end
	end

	// table entries are distinct so at most one bit is set
	assign ifc.am_match = |ifc.match_vector;

endmodule

// ==== src/am_lock_fsm.sv ====
// marker lock state machine
`timescale 1ns/1ps

module am_lock_fsm
(
	input  logic                  i_clock,
	input  logic                  i_rst_n,
	input  logic                  i_accept,       // candidate judged this cycle
	input  logic                  i_block_lock,   // 66b sync lock from upstream
	input  logic                  i_timer_done,   // candidate sits on the expected slot
	input  am_lock_pkg::val_am_t  i_max_valid_am,
	input  am_lock_pkg::inv_am_t  i_max_invalid_am,
	am_match_if.fsm               ifc,
	output logic                  o_timer_restart,
	output logic                  o_am_lock,
	output logic                  o_resync,
	output logic                  o_start_of_lane,
	output logic                  o_check_bip
);

	import am_lock_pkg::*;

	lock_state_t              state;
	val_am_t                  val_count;   // good markers seen so far
	inv_am_t                  inv_count;   // bad markers in a row while locked
	logic                     judge;       // expected marker slot reached
	logic                     capture;     // first marker of a new search
	logic [$bits(val_am_t):0] val_next;    // one wider, no wrap at compare
	logic [$bits(inv_am_t):0] inv_next;

	assign judge   = i_accept && i_timer_done;
	assign capture = i_block_lock && (state == LOCK_INIT) && i_accept && ifc.am_match;

	// capture marker counts as the first, so the first period brings two
	assign val_next = (state == LOCK_FIRST) ? ($bits(val_next))'(2)
		: {1'b0, val_count} + 1'b1;
	assign inv_next = {1'b0, inv_count} + 1'b1;

	assign o_timer_restart = capture;  // period starts at the captured marker
	assign o_check_bip     = i_block_lock && (state == LOCKED) && judge;

	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state           <= LOCK_INIT;
			ifc.match_mask  <= '0;
			ifc.enable_mask <= 1'b0;
			val_count       <= '0;
			inv_count       <= '0;
			o_am_lock       <= 1'b0;
			o_resync        <= 1'b0;
			o_start_of_lane <= 1'b0;
		end
		else
		begin
			o_resync        <= 1'b0;  // single cycle pulses
			o_start_of_lane <= 1'b0;
			if (!i_block_lock)
			begin
				// lost block sync, start over without resync request
				state           <= LOCK_INIT;
				ifc.match_mask  <= '0;
				ifc.enable_mask <= 1'b0;
				val_count       <= '0;
				inv_count       <= '0;
				o_am_lock       <= 1'b0;
			end
			else
			begin
				case (state)
					LOCK_INIT:
					begin
						if (capture)
						begin
							ifc.match_mask  <= ifc.match_vector;  // lane of this marker
							ifc.enable_mask <= 1'b1;
							inv_count       <= '0;
							if (i_max_valid_am <= val_am_t'(1))
							begin
								state     <= LOCKED;  // single marker is enough
								o_am_lock <= 1'b1;
							end
							else
								state <= LOCK_FIRST;
						end
					end
					LOCK_FIRST, LOCK_COUNT:
					begin
						if (judge && ifc.am_match)
						begin
							val_count <= val_next[$bits(val_am_t)-1:0];
							if (val_next >= {1'b0, i_max_valid_am})
							begin
								state     <= LOCKED;
								o_am_lock <= 1'b1;
							end
							else
								state <= LOCK_COUNT;
						end
						else if (judge)
						begin
							state           <= LOCK_INIT;  // off period or wrong lane
							ifc.match_mask  <= '0;
							ifc.enable_mask <= 1'b0;
							val_count       <= '0;
						end
					end
					LOCKED:
					begin
						if (judge && ifc.am_match)
						begin
							inv_count       <= '0;  // misses must be consecutive
							o_start_of_lane <= 1'b1;
						end
						else if (judge && (inv_next >= {1'b0, i_max_invalid_am}))
						begin
							state           <= LOCK_INIT;
							ifc.match_mask  <= '0;
							ifc.enable_mask <= 1'b0;
							val_count       <= '0;
							inv_count       <= '0;
							o_am_lock       <= 1'b0;
							o_resync        <= 1'b1;  // ask upstream to realign
						end
						else if (judge)
							inv_count <= inv_next[$bits(inv_am_t)-1:0];
					end
					default:
						state <= LOCK_INIT;
				endcase
			end
		end
	end

endmodule

// ==== src/am_lock_module.sv ====
// alignment marker lock top level
`timescale 1ns/1ps

module am_lock_module
#(
	parameter int N_ALIGNER = 20,     // lanes searched, at most 20
	parameter int N_BLOCKS  = 16384   // marker period in blocks
)
(
	input  logic                        i_clock,
	input  logic                        i_rst_n,
	input  logic                        i_enable,
	input  logic                        i_valid,
	input  logic                        i_block_lock,
	input  pcs_block_pkg::coded_block_t i_data,
	input  am_lock_pkg::inv_am_t        i_max_invalid_am,
	input  am_lock_pkg::val_am_t        i_max_valid_am,
	output pcs_block_pkg::coded_block_t o_data,
	output am_lock_pkg::lane_id_t       o_lane_id,       // valid while o_am_lock
	output am_lock_pkg::err_count_t     o_error_counter,
	output logic                        o_am_lock,
	output logic                        o_resync,
	output logic                        o_start_of_lane
);

	import pcs_block_pkg::*;
	import am_lock_pkg::*;

	// marker replacement, control header + eight idles
	localparam coded_block_t IDLE_BLOCK = {CTRL_SH, BLOCK_TYPE_CTRL, {8{PCS_IDLE}}};

	logic         accept;      // block taken from the input
	logic         cand_valid;  // candidate register holds a real block
	logic         blk_accept;  // candidate moves to output
	coded_block_t candidate;
	coded_block_t out_block;
	logic         timer_restart;
	logic         timer_done;
	logic         check_bip;

	am_match_if #(.N_ALIGNER(N_ALIGNER)) u_match_if ();

	assign accept     = i_valid && i_enable;
	assign blk_accept = accept && cand_valid;

	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			cand_valid <= 1'b0;
		else if (accept)
			cand_valid <= 1'b1;  // stays set after the first block
	end

	// two stage block pipeline
	always_ff @(posedge i_clock)
	begin
		if (accept)
			candidate <= i_data;
		if (blk_accept)
			out_block <= u_match_if.am_match ? IDLE_BLOCK : candidate;  // drop markers
	end

	assign o_data = out_block;

	// one-hot lane mask to lane number
	always_comb
	begin
		o_lane_id = '0;
		for (int i = 0; i < N_ALIGNER; i++)
		begin
			if (u_match_if.match_mask[i])
				o_lane_id = lane_id_t'(i);
		end
	end

	am_lock_comparator #(.N_ALIGNER(N_ALIGNER)) u_comparator
	(
		.ifc         (u_match_if),
		.i_candidate (candidate)
	);

	am_period_timer #(.N_BLOCKS(N_BLOCKS)) u_period_timer
	(
		.i_clock      (i_clock),
		.i_rst_n      (i_rst_n),
		.i_restart    (timer_restart),
		.i_accept     (blk_accept),
		.o_timer_done (timer_done)
	);

	am_lock_fsm u_lock_fsm
	(
		.i_clock          (i_clock),
		.i_rst_n          (i_rst_n),
		.i_accept         (blk_accept),
		.i_block_lock     (i_block_lock),
		.i_timer_done     (timer_done),
		.i_max_valid_am   (i_max_valid_am),
		.i_max_invalid_am (i_max_invalid_am),
		.ifc              (u_match_if),
		.o_timer_restart  (timer_restart),
		.o_am_lock        (o_am_lock),
		.o_resync         (o_resync),
		.o_start_of_lane  (o_start_of_lane),
		.o_check_bip      (check_bip)
	);

	bip_error_counter u_bip_counter
	(
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_accept      (blk_accept),
		.i_candidate   (candidate),
		.i_is_marker   (u_match_if.am_match),
		.i_check       (check_bip),
		.o_error_count (o_error_counter)
	);

endmodule

// ==== src/am_lock_pkg.sv ====
// marker lock types
package am_lock_pkg;

	// lock FSM states
	typedef enum logic [1:0]
	{
		LOCK_INIT,   // hunting for any marker
		LOCK_FIRST,  // lane captured, first period pending
		LOCK_COUNT,  // counting good markers toward lock
		LOCKED       // lane locked, watching for bad markers
	} lock_state_t;

	typedef logic [4:0]  lane_id_t;    // up to 20 lanes
	typedef logic [31:0] err_count_t;  // saturating BIP error count
	typedef logic [2:0]  inv_am_t;     // unlock threshold, bad markers in a row
	typedef logic [4:0]  val_am_t;     // lock threshold, good markers in a row

endpackage

// ==== src/am_match_if.sv ====
// comparator to lock FSM link
`timescale 1ns/1ps

interface am_match_if
#(
	parameter int N_ALIGNER = 20
);

	logic [N_ALIGNER-1:0] match_mask;    // one-hot captured lane
	logic                 enable_mask;   // restrict match to captured lane
	logic [N_ALIGNER-1:0] match_vector;  // one bit per matching lane
	logic                 am_match;      // candidate is a marker

	modport comparator
	(
		input  match_mask,
		input  enable_mask,
		output match_vector,
		output am_match
	);

	modport fsm
	(
		output match_mask,
		output enable_mask,
		input  match_vector,
		input  am_match
	);

endinterface

// ==== src/am_period_timer.sv ====
// marker period timer
`timescale 1ns/1ps

module am_period_timer
#(
	parameter int N_BLOCKS = 16384
)
(
	input  logic i_clock,
	input  logic i_rst_n,
	input  logic i_restart,  // marker captured, align period to it
	input  logic i_accept,   // candidate moved on
	output logic o_timer_done
);

	localparam int NB_COUNT = $clog2(N_BLOCKS + 1);

	logic [NB_COUNT-1:0] count;  // blocks left until next expected marker

	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			count <= NB_COUNT'(N_BLOCKS);
		else if (i_restart || (i_accept && o_timer_done))
			count <= NB_COUNT'(N_BLOCKS);  // reload, free running between restarts
		else if (i_accept)
			count <= count - NB_COUNT'(1);
	end

	// candidate is the N_BLOCKS-th block after the last marker
	assign o_timer_done = (count == NB_COUNT'(1));

endmodule

// ==== src/bip_error_counter.sv ====
// BIP3 error counter
`timescale 1ns/1ps

module bip_error_counter
(
	input  logic                        i_clock,
	input  logic                        i_rst_n,
	input  logic                        i_accept,      // candidate moved on
	input  pcs_block_pkg::coded_block_t i_candidate,
	input  logic                        i_is_marker,   // comparator hit on candidate
	input  logic                        i_check,       // expected marker slot while locked
	output am_lock_pkg::err_count_t     o_error_count
);

	import pcs_block_pkg::*;

	bip_t bip_acc;    // running parity since last marker
	bip_t block_bip;  // parity of the candidate alone
	bip_t rx_bip;
	logic bip_error;

	// bit j collects payload bits i with i mod 8 == j
	always_comb
	begin
		block_bip = '0;
		for (int i = 0; i < LEN_CODED_BLOCK - 2; i++)
		begin
			block_bip[i % 8] ^= i_candidate[i];
		end
		block_bip[3] ^= i_candidate[LEN_CODED_BLOCK-2];  // sh bit 0
		block_bip[4] ^= i_candidate[LEN_CODED_BLOCK-1];  // sh bit 1
	end

	assign rx_bip    = i_candidate[39:32];  // BIP3 field of the marker
	assign bip_error = i_check && i_is_marker && (rx_bip != bip_acc);

	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			bip_acc       <= '0;
			o_error_count <= '0;
		end
		else if (i_accept)
		begin
			// markers and missed marker slots close the window
			if (i_is_marker || i_check)
				bip_acc <= '0;
			else
				bip_acc <= bip_acc ^ block_bip;
			if (bip_error && (o_error_count != '1))
				o_error_count <= o_error_count + 1'b1;  // saturate at all ones
		end
	end

endmodule

// ==== src/pcs_block_pkg.sv ====
// 64b/66b coded block definitions
package pcs_block_pkg;

	localparam int LEN_CODED_BLOCK = 66;                   // sync header + 64 payload bits
	localparam int N_LANES_MAX     = 20;                   // 100G lane count

	typedef logic [LEN_CODED_BLOCK-1:0] coded_block_t;
	typedef logic [1:0]                 sync_hdr_t;        // bits 65:64
	typedef logic [47:0]                am_marker_t;       // {bits 63:40, bits 31:8}
	typedef logic [7:0]                 bip_t;             // rx BIP3 in bits 39:32

	localparam sync_hdr_t  CTRL_SH         = 2'b10;        // control block header
	localparam logic [7:0] BLOCK_TYPE_CTRL = 8'h1E;        // all control characters
	localparam logic [6:0] PCS_IDLE        = 7'h00;        // idle control character

	// 100G lane markers, M0 M1 M2 then M4 M5 M6, index = lane
	localparam am_marker_t AM_TABLE [N_LANES_MAX] = '{
		48'hC16821_3E97DE, 48'h9D718E_628E71, 48'h594BE8_A6B417, 48'h4D957B_B26A84,
		48'hF50709_0AF8F6, 48'hDD14C2_22EB3D, 48'h9A4A26_65B5D9, 48'h7B4566_84BA99,
		48'hA02476_5FDB89, 48'h68C9FB_973604, 48'hFD6C99_029366, 48'hB99155_466EAA,
		48'h5CB9B2_A3464D, 48'h1AF8BD_E50742, 48'h83C7CA_7C3835, 48'h3536CD_CAC932,
		48'hC4314C_3BCEB3, 48'hADD6B7_522948, 48'h5F662A_A099D5, 48'hC0F0E5_3F0F1A
	};
	// second half of each entry is the bitwise inverse of the first

endpackage

// ==== verification/am_lock_assertions.sv ====
// lock output protocol assertions
`timescale 1ns/1ps

module am_lock_assertions
(
	input logic i_clock,
	input logic i_rst_n,
	input logic i_am_lock,
	input logic i_resync,
	input logic i_start_of_lane
);

	// resync request is a one cycle pulse
	resync_single_pulse: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_resync |=> !i_resync)
		else $error("o_resync held high for more than one cycle");

	// resync only comes with a lock loss
	resync_not_on_lock_rise: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		!(i_resync && $rose(i_am_lock)))
		else $error("o_resync pulsed while o_am_lock rose");

	start_of_lane_locked: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_start_of_lane |-> i_am_lock)
		else $error("o_start_of_lane pulsed without lock");

endmodule

// attached to every instance of the top level
bind am_lock_module am_lock_assertions u_assertions
(
	.i_clock         (i_clock),
	.i_rst_n         (i_rst_n),
	.i_am_lock       (o_am_lock),
	.i_resync        (o_resync),
	.i_start_of_lane (o_start_of_lane)
);

// ==== verification/am_lock_tb.sv ====
// marker lock testbench
`timescale 1ns/1ps

module am_lock_tb;

	import pcs_block_pkg::*;
	import am_lock_pkg::*;

	localparam int N_BLOCKS = 16;   // short marker period
	localparam int N_ROWS   = 24;
	localparam int PERIOD   = 40;
	localparam int MAX_GOOD = 3;    // markers to lock
	localparam int MAX_BAD  = 3;    // misses in a row to unlock
	localparam coded_block_t IDLE_BLOCK = {2'b10, 8'h1E, 56'h0};

	// one marker period per row
	typedef struct packed
	{
		lane_id_t lane;
		logic     bad_am;    // flip one pattern bit
		logic     bad_bip;   // wrong BIP3
		logic     blk_lock;  // upstream block lock during the period
	} row_t;

	localparam row_t ROWS [N_ROWS] = '{
		'{5'd5, 1'b0, 1'b0, 1'b1}, '{5'd5, 1'b0, 1'b0, 1'b1},    // lane 5 hunt
		'{5'd5, 1'b0, 1'b0, 1'b1}, '{5'd5, 1'b0, 1'b1, 1'b1},    // lock then BIP error
		'{5'd5, 1'b0, 1'b0, 1'b1}, '{5'd5, 1'b1, 1'b0, 1'b1},
		'{5'd5, 1'b1, 1'b0, 1'b1}, '{5'd5, 1'b0, 1'b0, 1'b1},    // two misses then good
		'{5'd5, 1'b0, 1'b1, 1'b1}, '{5'd5, 1'b1, 1'b0, 1'b1},
		'{5'd5, 1'b1, 1'b0, 1'b1}, '{5'd5, 1'b1, 1'b0, 1'b1},    // third miss gives resync
		'{5'd5, 1'b0, 1'b0, 1'b1}, '{5'd5, 1'b0, 1'b0, 1'b1},
		'{5'd5, 1'b0, 1'b0, 1'b1}, '{5'd5, 1'b0, 1'b0, 1'b0},    // relock then block lock lost
		'{5'd12, 1'b0, 1'b0, 1'b1}, '{5'd12, 1'b0, 1'b0, 1'b1},  // new lane
		'{5'd12, 1'b0, 1'b1, 1'b1}, '{5'd12, 1'b0, 1'b1, 1'b1},  // unchecked at lock edge
		'{5'd12, 1'b0, 1'b0, 1'b1}, '{5'd7, 1'b0, 1'b0, 1'b1},   // foreign lane is a miss
		'{5'd12, 1'b0, 1'b0, 1'b1}, '{5'd12, 1'b0, 1'b0, 1'b1}
	};

	logic         clock;
	logic         rst_n;
	logic         enable;
	logic         valid;
	logic         block_lock;
	coded_block_t data_in;
	coded_block_t data_out;
	lane_id_t     lane_id;
	err_count_t   error_count;
	logic         am_lock;
	logic         resync;
	logic         start_of_lane;

	// reference model state 0 hunt 1 counting 2 locked
	int           m_state = 0;
	int           m_lane = 0;
	int           m_good = 0;
	int           m_miss = 0;
	int           exp_err = 0;
	int           exp_resync = 0;
	int           exp_sol = 0;
	int           resync_seen = 0;
	int           sol_seen = 0;
	int           n_taken = 0;
	logic         took = 1'b0;
	bip_t         prev_bip = '0;   // parity of the last period's data blocks
	coded_block_t exp_q [$];       // expected o_data in order

	clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(10)) u_clock_gen
	(
		.o_clock (clock),
		.o_rst_n (rst_n)
	);

	am_lock_module #(.N_ALIGNER(20), .N_BLOCKS(N_BLOCKS)) u_dut
	(
		.i_clock          (clock),
		.i_rst_n          (rst_n),
		.i_enable         (enable),
		.i_valid          (valid),
		.i_block_lock     (block_lock),
		.i_data           (data_in),
		.i_max_invalid_am (inv_am_t'(MAX_BAD)),
		.i_max_valid_am   (val_am_t'(MAX_GOOD)),
		.o_data           (data_out),
		.o_lane_id        (lane_id),
		.o_error_counter  (error_count),
		.o_am_lock        (am_lock),
		.o_resync         (resync),
		.o_start_of_lane  (start_of_lane)
	);

	task automatic check_equal(input logic [65:0] actual, input logic [65:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("Checks failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// payload bytes folded together with header bits on 3 and 4
	function automatic bip_t block_parity(input coded_block_t blk);
		bip_t p;
		p = '0;
		for (int b = 0; b < 8; b++)
			p ^= blk[8*b +: 8];
		p[3] ^= blk[64];
		p[4] ^= blk[65];
		return p;
	endfunction

	// judge one expected marker and tell whether it leaves as idle
	function automatic logic judge_marker(input row_t r);
		logic hit;
		hit = !r.bad_am;
		if (!r.blk_lock)
		begin
			m_state = 0;  // no capture without block lock
			return hit;
		end
		if (m_state == 0)
		begin
			if (hit)
			begin
				m_lane  = r.lane;
				m_good  = 1;
				m_miss  = 0;
				m_state = (m_good >= MAX_GOOD) ? 2 : 1;
			end
			return hit;
		end
		hit = hit && (r.lane == m_lane);  // mask set after capture
		if (m_state == 1)
		begin
			m_good++;
			if (!hit)
				m_state = 0;
			else if (m_good >= MAX_GOOD)
				m_state = 2;
		end
		else if (hit)
		begin
			m_miss = 0;
			exp_sol++;
			if (r.bad_bip)
				exp_err++;
		end
		else
		begin
			m_miss++;
			if (m_miss >= MAX_BAD)
			begin
				m_state = 0;
				m_miss  = 0;
				exp_resync++;
			end
		end
		return hit;
	endfunction

	task automatic send_block(input coded_block_t blk, input coded_block_t expected,
		input logic lock);
		int gap;
		gap = $urandom_range(0, 7);
		if (gap < 2)
		begin
			@(posedge clock);
			valid  <= gap[0];  // idle cycle with valid or enable low
			enable <= !gap[0];
		end
		@(posedge clock);
		valid      <= 1'b1;
		enable     <= 1'b1;
		data_in    <= blk;
		block_lock <= lock;
		exp_q.push_back(expected);
	endtask

	task automatic send_row(input row_t r);
		am_marker_t   pat;
		bip_t         bip;
		bip_t         acc;
		coded_block_t marker;
		coded_block_t blk;
		logic         replaced;
		pat = AM_TABLE[r.lane];
		if (r.bad_am)
			pat[20] = ~pat[20];
		bip      = r.bad_bip ? (prev_bip ^ 8'h5A) : prev_bip;
		marker   = {2'b10, pat[47:24], bip, pat[23:0], ~bip};
		replaced = judge_marker(r);
		send_block(marker, replaced ? IDLE_BLOCK : marker, r.blk_lock);
		acc = '0;
		for (int i = 1; i < N_BLOCKS; i++)
		begin
			blk = {2'b01, $urandom(), $urandom()};  // data header is never a marker
			acc ^= block_parity(blk);
			send_block(blk, blk, r.blk_lock);
		end
		prev_bip = acc;
	endtask

	always @(posedge clock)
		took <= rst_n && valid && enable;

	// pulse counters and output stream compare
	always @(negedge clock)
	begin
		if (resync)
			resync_seen++;
		if (start_of_lane)
			sol_seen++;
		if (took)
		begin
			n_taken++;
			if (n_taken >= 2)
				check_equal(data_out, exp_q.pop_front(), "o_data");
		end
	end

	initial
	begin
		#((N_ROWS * 17 * 4 + 20) * PERIOD);
		$display("Timeout: the run did not finish in time");
		$display("Checks failed");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		void'($urandom(56));
		enable     = 1'b0;
		valid      = 1'b0;
		block_lock = 1'b0;
		data_in    = '0;
		@(posedge rst_n);
		@(negedge clock);
		check_equal(am_lock, 1'b0, "o_am_lock after reset");
		check_equal(resync, 1'b0, "o_resync after reset");
		check_equal(start_of_lane, 1'b0, "o_start_of_lane after reset");
		check_equal(error_count, '0, "o_error_counter after reset");
		for (int r = 0; r < N_ROWS; r++)
		begin
			send_row(ROWS[r]);
			@(negedge clock);
			check_equal(am_lock, m_state == 2, $sformatf("o_am_lock, row %0d", r));
			if (m_state == 2)
				check_equal(lane_id, m_lane, $sformatf("o_lane_id, row %0d", r));
			check_equal(error_count, exp_err, $sformatf("o_error_counter, row %0d", r));
			check_equal(resync_seen, exp_resync, $sformatf("resync pulses, row %0d", r));
			check_equal(sol_seen, exp_sol, $sformatf("start of lane pulses, row %0d", r));
		end
		send_block(IDLE_BLOCK, IDLE_BLOCK, 1'b1);  // pushes the final data block to o_data
		@(posedge clock);
		valid <= 1'b0;
		repeat (3)
			@(negedge clock);
		$display("All checks passed");
		$finish;
	end

endmodule

// ==== verification/clock_gen.sv ====
// testbench clock and reset
`timescale 1ns/1ps

module clock_gen
#(
	parameter int PERIOD       = 40,  // ns
	parameter int RESET_CYCLES = 10
)
(
	output logic o_clock,
	output logic o_rst_n
);

	initial
	begin
		o_clock = 1'b0;
		forever
			#(PERIOD / 2) o_clock = ~o_clock;
	end

	initial
	begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge o_clock);
		o_rst_n <= 1'b1;  // release on a rising edge
	end

endmodule
